// ==== include/trace_params.svh ====
`ifndef TRACE_PARAMS_SVH
`define TRACE_PARAMS_SVH

////////////////////////////////////////////////////////////
// trace record widths
////////////////////////////////////////////////////////////

// sequence number width, wraps after 256 records
`define TRACE_SEQ_W 8

// free-running cycle stamp width
`define TRACE_CYCLE_W 16

////////////////////////////////////////////////////////////
// pipeline storage sizes
////////////////////////////////////////////////////////////

`define PIPE_NUM_REGS 8
`define PIPE_SCRATCH_DEPTH 16

`endif

// ==== source/pipe_types_pkg.sv ====
`default_nettype none

`include "trace_params.svh"

package pipe_types_pkg;

    // instruction word
    // op in [15:12], rd in [11:9], [8] spare, imm in [7:0]
    typedef logic [15:0] insn_t;

    // register file and scratch data
    typedef logic [7:0] data_t;

    // register index
    typedef logic [$clog2(`PIPE_NUM_REGS)-1:0] reg_idx_t;

    // opcodes, anything else decodes as nop
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADDI = 4'd1,
        OP_XORI = 4'd2,
        OP_LD   = 4'd3,
        OP_ST   = 4'd4
    } opcode_t;

endpackage

`default_nettype wire

// ==== source/trace_types_pkg.sv ====
`default_nettype none

`include "trace_params.svh"

package trace_types_pkg;

    // per-instruction sequence number
    typedef logic [`TRACE_SEQ_W-1:0] seq_t;

    // cycle stamp
    typedef logic [`TRACE_CYCLE_W-1:0] cycle_t;

    // output handshake state
    // TR_REQ holds req high, TR_DROP waits for ack to fall
    typedef enum logic [1:0] {
        TR_IDLE,
        TR_REQ,
        TR_DROP
    } trace_hs_t;

endpackage

`default_nettype wire

// ==== source/pipe_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "trace_params.svh"

module pipe_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     fd_valid,
    input  pipe_types_pkg::insn_t    fd_insn,
    input  pipe_types_pkg::reg_idx_t ex_rd,
    input  pipe_types_pkg::reg_idx_t mem_rd,
    input  logic                     ex_writes,
    input  logic                     mem_writes,
    input  logic                     trace_busy,
    output logic                     fetch_take,
    output logic                     pipe_adv,
    output logic                     bubble,
    output logic                     dec_valid,
    output logic                     ex_valid,
    output logic                     mem_valid,
    output logic                     wb_valid
);
    import pipe_types_pkg::*;

    opcode_t  dec_op;
    reg_idx_t dec_src;
    logic     dec_reads;
    logic     hit_ex;
    logic     hit_mem;
    logic     retire_hold;
    logic     dec_leave;

    ////////////////////////////////////////////////////////////
    // interlock
    ////////////////////////////////////////////////////////////

    assign dec_op  = opcode_t'(fd_insn[15:12]);
    assign dec_src = fd_insn[11:9];

    // rd is also the source operand for these
    assign dec_reads = (dec_op inside {OP_ADDI, OP_XORI, OP_ST});

    // wb is covered by the write-first bypass in decode
    assign hit_ex  = ex_valid && ex_writes && (ex_rd == dec_src);
    assign hit_mem = mem_valid && mem_writes && (mem_rd == dec_src);
    assign bubble  = dec_valid && dec_reads && (hit_ex || hit_mem);

    ////////////////////////////////////////////////////////////
    // advance and back-pressure
    ////////////////////////////////////////////////////////////

    // retiring insn must wait for a free record slot
    assign retire_hold = wb_valid && trace_busy;
    assign pipe_adv    = (dec_valid || ex_valid || mem_valid || wb_valid) && !retire_hold;
    assign dec_leave   = dec_valid && pipe_adv && !bubble;

    // slot is free if empty or emptied this cycle
    assign fetch_take = !retire_hold && (!dec_valid || !bubble);

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
            ex_valid  <= 1'b0;
            mem_valid <= 1'b0;
            wb_valid  <= 1'b0;
        end else begin
            if (pipe_adv) begin
                // empty slot into execute on a hazard
                ex_valid  <= dec_valid && !bubble;
                mem_valid <= ex_valid;
                wb_valid  <= mem_valid;
            end
            if (fd_valid) begin
                dec_valid <= 1'b1;
            end else if (dec_leave) begin
                dec_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/fetch_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "trace_params.svh"

module fetch_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_req,
    input  pipe_types_pkg::insn_t in_insn,
    output logic                  in_ack,
    input  logic                  fetch_take,
    output logic                  fd_valid,
    output pipe_types_pkg::insn_t fd_insn
);

    // intake handshake states
    typedef enum logic {
        FS_IDLE,
        FS_ACK
    } fetch_state_t;

    fetch_state_t state;

    // latch only with req up, ack down and room in decode
    assign fd_valid = (state == FS_IDLE) && in_req && fetch_take;
    assign in_ack   = (state == FS_ACK);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FS_IDLE;
        end else begin
            case (state)
                FS_IDLE: if (fd_valid) state <= FS_ACK;
                // ack falls once the source drops req
                FS_ACK:  if (!in_req) state <= FS_IDLE;
                default: state <= FS_IDLE;
            endcase
        end
    end

    // fetch/decode register
    always_ff @(posedge clk) begin
        if (fd_valid) begin
            fd_insn <= in_insn;
        end
    end

endmodule

`default_nettype wire

// ==== source/pipe_datapath.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "trace_params.svh"

module pipe_datapath (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     pipe_adv,
    input  logic                     bubble,
    input  logic                     dec_valid,
    input  pipe_types_pkg::insn_t    fd_insn,
    output pipe_types_pkg::reg_idx_t ex_rd,
    output pipe_types_pkg::reg_idx_t mem_rd,
    output logic                     ex_writes,
    output logic                     mem_writes,
    output pipe_types_pkg::data_t    wb_result,
    output pipe_types_pkg::insn_t    wb_insn
);
    import pipe_types_pkg::*;

    data_t    regs [`PIPE_NUM_REGS];
    data_t    scratch [`PIPE_SCRATCH_DEPTH];

    reg_idx_t dec_rd;
    data_t    dec_rd_val;
    insn_t    ex_insn;
    opcode_t  ex_op;
    data_t    ex_rd_val;
    data_t    alu_out;
    insn_t    mem_insn;
    opcode_t  mem_op;
    data_t    mem_val;
    data_t    mem_out;
    logic [$clog2(`PIPE_SCRATCH_DEPTH)-1:0] mem_addr;
    logic     wb_writes;

    ////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////

    assign dec_rd = fd_insn[11:9];

    // write-first, wb value wins over the stored one
    assign dec_rd_val = (wb_writes && (wb_insn[11:9] == dec_rd)) ? wb_result : regs[dec_rd];

    ////////////////////////////////////////////////////////////
    // execute
    ////////////////////////////////////////////////////////////

    assign ex_op     = opcode_t'(ex_insn[15:12]);
    assign ex_rd     = ex_insn[11:9];
    assign ex_writes = (ex_op inside {OP_ADDI, OP_XORI, OP_LD});

    // st passes the store data, nop gives 0
    always_comb begin
        case (ex_op)
            OP_ADDI: alu_out = ex_rd_val + ex_insn[7:0];
            OP_XORI: alu_out = ex_rd_val ^ ex_insn[7:0];
            OP_ST:   alu_out = ex_rd_val;
            default: alu_out = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // memory and write-back
    ////////////////////////////////////////////////////////////

    assign mem_op     = opcode_t'(mem_insn[15:12]);
    assign mem_rd     = mem_insn[11:9];
    assign mem_writes = (mem_op inside {OP_ADDI, OP_XORI, OP_LD});
    assign mem_addr   = mem_insn[$clog2(`PIPE_SCRATCH_DEPTH)-1:0];
    assign mem_out    = (mem_op == OP_LD) ? scratch[mem_addr] : mem_val;

    assign wb_writes = (opcode_t'(wb_insn[15:12]) inside {OP_ADDI, OP_XORI, OP_LD});

    // slot words, empty slots travel as nop
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_insn  <= '0;
            mem_insn <= '0;
            wb_insn  <= '0;
        end else if (pipe_adv) begin
            ex_insn  <= (dec_valid && !bubble) ? fd_insn : '0;
            mem_insn <= ex_insn;
            wb_insn  <= mem_insn;
        end
    end

    always_ff @(posedge clk) begin
        if (pipe_adv) begin
            ex_rd_val <= dec_rd_val;
            mem_val   <= alu_out;
            wb_result <= mem_out;
        end
    end

    // state commits when its slot moves on, so a held slot writes once
    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (pipe_adv && wb_writes) begin
            regs[wb_insn[11:9]] <= wb_result;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            scratch <= '{default: '0};
        end else if (pipe_adv && (mem_op == OP_ST)) begin
            scratch[mem_addr] <= mem_val;
        end
    end

endmodule

`default_nettype wire

// ==== source/trace_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "trace_params.svh"

module trace_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pipe_adv,
    input  logic                    bubble,
    input  logic                    dec_valid,
    input  logic                    wb_valid,
    input  pipe_types_pkg::data_t   wb_result,
    input  pipe_types_pkg::insn_t   wb_insn,
    output logic                    trace_busy,
    output logic                    trace_req,
    input  logic                    trace_ack,
    output trace_types_pkg::seq_t   trace_seq,
    output pipe_types_pkg::insn_t   trace_insn,
    output pipe_types_pkg::data_t   trace_result,
    output trace_types_pkg::cycle_t trace_fetch_cycle,
    output trace_types_pkg::cycle_t trace_retire_cycle
);
    import trace_types_pkg::*;

    cycle_t    cycle_cnt;
    seq_t      next_seq;
    logic      dec_tagged;
    logic      dec_leave;
    logic      retire;
    seq_t      dec_seq_q;
    seq_t      dec_seq;
    cycle_t    dec_stamp_q;
    cycle_t    dec_stamp;
    seq_t      ex_seq;
    seq_t      mem_seq;
    seq_t      wb_seq;
    cycle_t    ex_stamp;
    cycle_t    mem_stamp;
    cycle_t    wb_stamp;
    trace_hs_t hs_state;

    ////////////////////////////////////////////////////////////
    // decode tagging
    ////////////////////////////////////////////////////////////

    assign dec_leave = dec_valid && pipe_adv && !bubble;

    // untagged means first cycle in decode, fetch was one cycle back
    assign dec_seq   = dec_tagged ? dec_seq_q : next_seq;
    assign dec_stamp = dec_tagged ? dec_stamp_q : cycle_cnt - cycle_t'(1);

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_cnt  <= '0;
            next_seq   <= '0;
            dec_tagged <= 1'b0;
        end else begin
            cycle_cnt  <= cycle_cnt + cycle_t'(1);
            // still in decode next cycle
            dec_tagged <= dec_valid && !dec_leave;
            if (dec_valid && !dec_tagged) begin
                next_seq <= next_seq + seq_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid && !dec_tagged) begin
            dec_seq_q   <= dec_seq;
            dec_stamp_q <= dec_stamp;
        end
    end

    // tags ride along with the slots
    always_ff @(posedge clk) begin
        if (pipe_adv) begin
            ex_seq    <= dec_leave ? dec_seq : '0;
            ex_stamp  <= dec_leave ? dec_stamp : '0;
            mem_seq   <= ex_seq;
            mem_stamp <= ex_stamp;
            wb_seq    <= mem_seq;
            wb_stamp  <= mem_stamp;
        end
    end

    ////////////////////////////////////////////////////////////
    // record output
    ////////////////////////////////////////////////////////////

    // pipe_adv is held off while busy, so this only fires when idle
    assign retire     = wb_valid && pipe_adv;
    assign trace_req  = (hs_state == TR_REQ);
    assign trace_busy = (hs_state != TR_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            hs_state <= TR_IDLE;
        end else begin
            case (hs_state)
                TR_IDLE: if (retire) hs_state <= TR_REQ;
                TR_REQ:  if (trace_ack) hs_state <= TR_DROP;
                TR_DROP: if (!trace_ack) hs_state <= TR_IDLE;
                default: hs_state <= TR_IDLE;
            endcase
        end
    end

    // record stays put until the next retire
    always_ff @(posedge clk) begin
        if (retire) begin
            trace_seq          <= wb_seq;
            trace_insn         <= wb_insn;
            trace_result       <= wb_result;
            trace_fetch_cycle  <= wb_stamp;
            trace_retire_cycle <= cycle_cnt;
        end
    end

endmodule

`default_nettype wire

// ==== source/trace_pipe_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "trace_params.svh"

module trace_pipe_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_req,
    input  pipe_types_pkg::insn_t   in_insn,
    output logic                    in_ack,
    output logic                    trace_req,
    input  logic                    trace_ack,
    output trace_types_pkg::seq_t   trace_seq,
    output pipe_types_pkg::insn_t   trace_insn,
    output pipe_types_pkg::data_t   trace_result,
    output trace_types_pkg::cycle_t trace_fetch_cycle,
    output trace_types_pkg::cycle_t trace_retire_cycle
);
    import pipe_types_pkg::*;

    // fetch to decode
    logic     fd_valid;
    insn_t    fd_insn;
    logic     fetch_take;

    // control
    logic     pipe_adv;
    logic     bubble;
    logic     dec_valid;
    logic     ex_valid;
    logic     mem_valid;
    logic     wb_valid;
    logic     trace_busy;

    // hazard and retire info from the datapath
    reg_idx_t ex_rd;
    reg_idx_t mem_rd;
    logic     ex_writes;
    logic     mem_writes;
    data_t    wb_result;
    insn_t    wb_insn;

    fetch_stage u_fetch (
        .clk, .rst,
        .in_req, .in_insn, .in_ack,
        .fetch_take, .fd_valid, .fd_insn
    );

    pipe_ctrl u_ctrl (
        .clk, .rst,
        .fd_valid, .fd_insn,
        .ex_rd, .mem_rd, .ex_writes, .mem_writes, .trace_busy,
        .fetch_take, .pipe_adv, .bubble,
        .dec_valid, .ex_valid, .mem_valid, .wb_valid
    );

    pipe_datapath u_dp (
        .clk, .rst,
        .pipe_adv, .bubble, .dec_valid, .fd_insn,
        .ex_rd, .mem_rd, .ex_writes, .mem_writes,
        .wb_result, .wb_insn
    );

    trace_unit u_trace (
        .clk, .rst,
        .pipe_adv, .bubble, .dec_valid, .wb_valid,
        .wb_result, .wb_insn,
        .trace_busy, .trace_req, .trace_ack,
        .trace_seq, .trace_insn, .trace_result,
        .trace_fetch_cycle, .trace_retire_cycle
    );

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic clk
);

    // 40 ns period, low half first
    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// ==== tb/trace_pipe_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "trace_params.svh"

module trace_pipe_tb;
    import pipe_types_pkg::*;
    import trace_types_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_INSNS = 46;
    // 200 cycles per issued insn plus both resets
    localparam int TIMEOUT_CYCLES = 200 * NUM_INSNS + 2 * RESET_CYCLES;
    localparam logic [31:0] SEED = 32'h5307_5cac;

    logic   clk;
    logic   rst;
    logic   in_req;
    insn_t  in_insn;
    logic   in_ack;
    logic   trace_req;
    logic   trace_ack;
    seq_t   trace_seq;
    insn_t  trace_insn;
    data_t  trace_result;
    cycle_t trace_fetch_cycle;
    cycle_t trace_retire_cycle;
    cycle_t rec_span;

    // reference model state
    data_t model_regs [`PIPE_NUM_REGS];
    data_t model_mem [`PIPE_SCRATCH_DEPTH];

    // expected records in issue order since the last reset
    insn_t      exp_insn [64];
    data_t      exp_res [64];
    logic       exp_exact [64];
    logic [5:0] issue_cnt;
    logic [5:0] rec_cnt;

    string test_name;
    int    test_errs;
    int    err_total;
    int    tests_run;
    int    tests_failed;
    int    cycles;

    tb_clock u_clk (.clk);

    trace_pipe_top uut (
        .clk, .rst,
        .in_req, .in_insn, .in_ack,
        .trace_req, .trace_ack,
        .trace_seq, .trace_insn, .trace_result,
        .trace_fetch_cycle, .trace_retire_cycle
    );

    assign rec_span = trace_retire_cycle - trace_fetch_cycle;

    ////////////////////////////////////////////////////////////
    // failure reporting
    ////////////////////////////////////////////////////////////

    task automatic value_error(input string field, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        $display("Error %s: %s expected 0x%0h actual 0x%0h", test_name, field, exp_val, act_val);
        test_errs++;
        err_total++;
    endtask

    task automatic rule_error(input string what);
        $display("%s: %s", test_name, what);
        test_errs++;
        err_total++;
    endtask

    ////////////////////////////////////////////////////////////
    // record checks
    ////////////////////////////////////////////////////////////

    // no record without an outstanding insn
    rec_extra_chk: assert property (@(posedge clk) disable iff (rst)
        trace_req |-> rec_cnt < issue_cnt)
        else rule_error("record arrived with no instruction outstanding");

    rec_seq_chk: assert property (@(posedge clk) disable iff (rst)
        trace_req |-> trace_seq == seq_t'(rec_cnt))
        else value_error("trace_seq", 32'($sampled(rec_cnt)), 32'($sampled(trace_seq)));

    rec_insn_chk: assert property (@(posedge clk) disable iff (rst)
        trace_req |-> trace_insn == exp_insn[rec_cnt])
        else value_error("trace_insn", 32'($sampled(exp_insn[rec_cnt])),
                         32'($sampled(trace_insn)));

    rec_result_chk: assert property (@(posedge clk) disable iff (rst)
        trace_req |-> trace_result == exp_res[rec_cnt])
        else value_error("trace_result", 32'($sampled(exp_res[rec_cnt])),
                         32'($sampled(trace_result)));

    // five stages, so never under 4
    span_min_chk: assert property (@(posedge clk) disable iff (rst)
        trace_req |-> rec_span >= cycle_t'(4))
        else rule_error("retire minus fetch cycle is below 4");

    // stall free insns take exactly 4
    span_exact_chk: assert property (@(posedge clk) disable iff (rst)
        trace_req && exp_exact[rec_cnt] |-> rec_span == cycle_t'(4))
        else value_error("retire-fetch", 32'd4, 32'($sampled(rec_span)));

    rec_stable_chk: assert property (@(posedge clk) disable iff (rst)
        trace_req |=> $stable(trace_seq) && $stable(trace_insn) && $stable(trace_result)
            && $stable(trace_fetch_cycle) && $stable(trace_retire_cycle))
        else rule_error("trace record changed while trace_req was high");

    // back-pressure reaches the intake
    intake_hold_chk: assert property (@(posedge clk) disable iff (rst)
        trace_req && uut.wb_valid |=> !$rose(in_ack))
        else rule_error("in_ack rose while a retiring record waited for ack");

    reset_out_chk: assert property (@(posedge clk)
        rst |=> !trace_req && !in_ack)
        else rule_error("trace_req or in_ack high after reset");

    ////////////////////////////////////////////////////////////
    // model and stimulus
    ////////////////////////////////////////////////////////////

    function automatic insn_t make_insn(input logic [3:0] op, input reg_idx_t rd,
                                       input data_t imm);
        return {op, rd, 1'b0, imm};
    endfunction

    // sequential semantics with one insn at a time
    task automatic model_execute(input insn_t insn, output data_t res);
        reg_idx_t rd;
        data_t    imm;
        rd  = insn[11:9];
        imm = insn[7:0];
        case (insn[15:12])
            OP_ADDI: begin
                model_regs[rd] = model_regs[rd] + imm;
                res = model_regs[rd];
            end
            OP_XORI: begin
                model_regs[rd] = model_regs[rd] ^ imm;
                res = model_regs[rd];
            end
            OP_LD: begin
                model_regs[rd] = model_mem[imm[3:0]];
                res = model_regs[rd];
            end
            OP_ST: begin
                model_mem[imm[3:0]] = model_regs[rd];
                res = model_regs[rd];
            end
            // nop and unknown opcodes
            default: res = '0;
        endcase
    endtask

    // four-phase intake from one falling edge to another
    task automatic issue(input insn_t insn, input logic exact);
        data_t res;
        model_execute(insn, res);
        exp_insn[issue_cnt]  = insn;
        exp_res[issue_cnt]   = res;
        exp_exact[issue_cnt] = exact;
        issue_cnt = issue_cnt + 6'd1;
        in_insn = insn;
        in_req  = 1'b1;
        do @(negedge clk); while (!in_ack);
        in_req = 1'b0;
        do @(negedge clk); while (in_ack);
    endtask

    // a pending req is held into reset and withdrawn before it ends
    task automatic apply_reset();
        rst = 1'b1;
        model_regs = '{default: '0};
        model_mem  = '{default: '0};
        issue_cnt  = '0;
        repeat (RESET_CYCLES - 1) @(negedge clk);
        in_req = 1'b0;
        @(negedge clk);
        rst = 1'b0;
    endtask

    // wait until every issued insn has been traced
    task automatic drain();
        while (rec_cnt != issue_cnt) begin
            @(negedge clk);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        drain();
        tests_run++;
        if (test_errs == 0) begin
            $display("test %s: pass", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, test_errs);
        end
    endtask

    // sink with a random ack delay of 0 to 5 cycles
    initial begin : ack_sink
        int delay;
        trace_ack = 1'b0;
        void'($urandom(SEED));
        forever begin
            @(negedge clk);
            if (rst) begin
                rec_cnt = '0;
            end else if (trace_req) begin
                delay = $urandom % 6;
                repeat (delay) @(negedge clk);
                trace_ack = 1'b1;
                do @(negedge clk); while (trace_req);
                trace_ack = 1'b0;
                rec_cnt = rec_cnt + 6'd1;
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the DUT stopped answering", cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : main_seq
        rst          = 1'b1;
        in_req       = 1'b0;
        in_insn      = '0;
        err_total    = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_errs    = 0;
        test_name    = "reset";
        @(negedge clk);
        apply_reset();

        // 4'hf and 4'h9 are unknown opcodes
        start_test("seq_order");
        issue(make_insn(OP_NOP, 3'd0, 8'h00), 1'b0);
        issue(make_insn(OP_ADDI, 3'd1, 8'h01), 1'b0);
        issue(make_insn(4'hF, 3'd2, 8'h33), 1'b0);
        issue(make_insn(OP_ADDI, 3'd3, 8'h05), 1'b0);
        issue(make_insn(4'h9, 3'd4, 8'h77), 1'b0);
        issue(make_insn(OP_XORI, 3'd5, 8'hA5), 1'b0);
        end_test();

        start_test("alu_wrap");
        issue(make_insn(OP_ADDI, 3'd2, 8'hF0), 1'b0);
        issue(make_insn(OP_ADDI, 3'd2, 8'h20), 1'b0);
        issue(make_insn(OP_XORI, 3'd2, 8'hFF), 1'b0);
        issue(make_insn(OP_ADDI, 3'd4, 8'hFF), 1'b0);
        issue(make_insn(OP_ADDI, 3'd4, 8'h02), 1'b0);
        issue(make_insn(OP_NOP, 3'd4, 8'h12), 1'b0);
        issue(make_insn(OP_XORI, 3'd2, 8'hEF), 1'b0);
        end_test();

        // 8'h1f and 8'h0f hit the same byte
        start_test("store_load");
        issue(make_insn(OP_ADDI, 3'd5, 8'h3C), 1'b0);
        issue(make_insn(OP_ST, 3'd5, 8'h07), 1'b0);
        issue(make_insn(OP_LD, 3'd6, 8'h07), 1'b0);
        issue(make_insn(OP_ST, 3'd6, 8'h1F), 1'b0);
        issue(make_insn(OP_LD, 3'd1, 8'h0F), 1'b0);
        issue(make_insn(OP_LD, 3'd7, 8'h03), 1'b0);
        end_test();

        start_test("dep_addi");
        repeat (5) issue(make_insn(OP_ADDI, 3'd1, 8'h11), 1'b0);
        end_test();

        // pipeline empty before each issue
        start_test("gap_exact");
        issue(make_insn(OP_ADDI, 3'd1, 8'h01), 1'b1);
        drain();
        issue(make_insn(OP_XORI, 3'd3, 8'h0F), 1'b1);
        drain();
        issue(make_insn(OP_ST, 3'd2, 8'h09), 1'b1);
        drain();
        issue(make_insn(OP_LD, 3'd4, 8'h09), 1'b1);
        end_test();

        // back-to-back issue outruns the sink
        start_test("slow_sink");
        for (int i = 0; i < 12; i++) begin
            issue(make_insn(4'(i % 5), 3'(i % 3), 8'(i * 37)), 1'b0);
        end
        end_test();

        // reset hits with in_ack and trace_req both up
        start_test("mid_reset");
        issue(make_insn(OP_ADDI, 3'd1, 8'h01), 1'b0);
        issue(make_insn(OP_ADDI, 3'd1, 8'h01), 1'b0);
        in_insn = make_insn(OP_XORI, 3'd1, 8'hFF);
        in_req  = 1'b1;
        do @(negedge clk); while (!in_ack);
        apply_reset();
        issue(make_insn(OP_ADDI, 3'd1, 8'h05), 1'b0);
        issue(make_insn(OP_LD, 3'd2, 8'h00), 1'b0);
        issue(make_insn(OP_ADDI, 3'd1, 8'h01), 1'b0);
        end_test();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_total);
        if (err_total == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+include
source/pipe_types_pkg.sv
source/trace_types_pkg.sv
source/pipe_ctrl.sv
source/fetch_stage.sv
source/pipe_datapath.sv
source/trace_unit.sv
source/trace_pipe_top.sv
tb/tb_clock.sv
tb/trace_pipe_tb.sv

// ==== Makefile ====
# Verilator build and run for the trace pipeline testbench

VERILATOR  ?= verilator
TOP        := trace_pipe_tb
FILELIST   := compile.f
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# the run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
